// File: files.f
+incdir+rtl
rtl/scaler_ctl_pkg.sv
rtl/host_link.sv
rtl/cfg_regs.sv
rtl/umuldiv.sv
rtl/window_calc.sv
rtl/scaler_ctl_top.sv
bench/tb_scaler_ctl.sv

// File: Makefile
# Verilator build and run of the scaler control testbench

VERILATOR ?= verilator
TOP       ?= tb_scaler_ctl
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation, fail if the log reports failure"
	@echo "  clean  remove the build folder and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "no pass message in $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_scaler_ctl.sv
//////////////////////////////////////////////////////////////////////
// scaler control testbench
// host frames over req/ack, window bounds and LED mux checks
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "scaler_ctl_cfg.svh"

module tb_scaler_ctl;

	timeunit 1ns;
	timeprecision 1ps;

	// window settles within two sequencer passes
	localparam int SETTLE_CYCLES = 64;
	localparam int MAX_CYCLES    = 6000;

	logic                   clk_sys;
	logic                   resetd;
	logic                   i_host_req;
	logic                   i_host_sel;
	logic [`CFG_WORD_W-1:0] i_host_data;
	logic [7:0]             i_led_status;
	logic [`CFG_DIM_W-1:0]  i_arx;
	logic [`CFG_DIM_W-1:0]  i_ary;
	wire                    o_host_ack;
	wire  [7:0]             o_led;
	wire  [`CFG_DIM_W-1:0]  o_hmin;
	wire  [`CFG_DIM_W-1:0]  o_hmax;
	wire  [`CFG_DIM_W-1:0]  o_vmin;
	wire  [`CFG_DIM_W-1:0]  o_vmax;

	int errors = 0;
	int tests_run = 0;
	int cycles = 0;
	int ack_wait = 0;
	int seed;
	logic [`CFG_WORD_W-1:0] frame_words[$];

	// host side view of the configuration
	int         mdl_w;
	int         mdl_h;
	int         mdl_vs;
	int         mdl_hs;
	int         mdl_ax;
	int         mdl_ay;
	bit         mdl_fs;
	logic [7:0] mdl_mask;
	logic [7:0] mdl_state;

	scaler_ctl_top dut_i (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_host_req   (i_host_req),
		.i_host_sel   (i_host_sel),
		.i_host_data  (i_host_data),
		.i_led_status (i_led_status),
		.i_arx        (i_arx),
		.i_ary        (i_ary),
		.o_host_ack   (o_host_ack),
		.o_led        (o_led),
		.o_hmin       (o_hmin),
		.o_hmax       (o_hmax),
		.o_vmin       (o_vmin),
		.o_vmax       (o_vmax)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// handshake checks
	//////////////////////////////////////////////////////////////////////

	ack_rise_needs_req: assert property (@(posedge clk_sys) disable iff (resetd)
		$rose(o_host_ack) |-> i_host_req)
		else begin
			$display("handshake: ack rose while req was low");
			errors++;
		end

	ack_fall_needs_no_req: assert property (@(posedge clk_sys) disable iff (resetd)
		$fell(o_host_ack) |-> !i_host_req)
		else begin
			$display("handshake: ack fell while req was still high");
			errors++;
		end

	// cycles spent with req high and no ack yet
	always @(posedge clk_sys) begin
		if (resetd || !i_host_req || o_host_ack) begin
			ack_wait <= 0;
		end else begin
			ack_wait <= ack_wait + 1;
			assert (ack_wait != 8) else begin
				$display("handshake: req was not answered within 8 cycles");
				errors++;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// host tasks and checkers
	//////////////////////////////////////////////////////////////////////

	// one four-phase word transfer
	task automatic send_word(input logic [`CFG_WORD_W-1:0] w);
		@(posedge clk_sys);
		i_host_data <= w;
		i_host_req  <= 1'b1;
		do @(posedge clk_sys); while (!o_host_ack);
		i_host_req <= 1'b0;
		do @(posedge clk_sys); while (o_host_ack);
	endtask

	// words of frame_words under one select pulse
	task automatic send_frame();
		@(posedge clk_sys);
		i_host_sel <= 1'b1;
		repeat (3) @(posedge clk_sys);
		foreach (frame_words[k])
			send_word(frame_words[k]);
		@(posedge clk_sys);
		i_host_sel <= 1'b0;
		repeat (4) @(posedge clk_sys);
		frame_words.delete();
	endtask

	task automatic compare_value(input string name, input string what, input int exp,
			input int act);
		assert (act == exp) else begin
			$display("[FAIL] %s %s expected %0d actual %0d", name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_bounds(input string name, input int hmin, input int hmax,
			input int vmin, input int vmax);
		compare_value(name, "hmin", hmin, int'(o_hmin));
		compare_value(name, "hmax", hmax, int'(o_hmax));
		compare_value(name, "vmin", vmin, int'(o_vmin));
		compare_value(name, "vmax", vmax, int'(o_vmax));
	endtask

	// limit, aspect, clip and centre rules on the host side state
	task automatic check_window(input string name);
		int lw;
		int lh;
		int vw;
		int vh;
		int hmin;
		int vmin;
		lw = (mdl_hs != 0 && mdl_hs < mdl_w) ? mdl_hs : mdl_w;
		lh = (mdl_vs != 0 && mdl_vs < mdl_h) ? mdl_vs : mdl_h;
		if (mdl_fs || mdl_ax == 0 || mdl_ay == 0) begin
			vw = lw;
			vh = lh;
		end else begin
			vw = (lh * mdl_ax) / mdl_ay;
			vh = (lw * mdl_ay) / mdl_ax;
		end
		// a saturated quotient is above any limit, so the clip covers it
		if (vw > lw)
			vw = lw;
		if (vh > lh)
			vh = lh;
		hmin = (mdl_w - vw) / 2;
		vmin = (mdl_h - vh) / 2;
		check_bounds(name, hmin, hmin + vw - 1, vmin, vmin + vh - 1);
	endtask

	// host state on masked bits and core status on the others
	task automatic check_led(input string name);
		logic [7:0] exp;
		for (int b = 0; b < 8; b++) begin
			if (mdl_mask[b])
				exp[b] = mdl_state[b];
			else
				exp[b] = i_led_status[b];
		end
		compare_value(name, "o_led", int'(exp), int'(o_led));
	endtask

	task automatic end_test(input string name, input int errs_at_start);
		tests_run++;
		if (errors == errs_at_start)
			$display("[done] %s passed", name);
		else
			$display("[done] %s failed with %0d errors", name, errors - errs_at_start);
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int          start_err;
		logic [31:0] rnd;
		seed = 32'h3df7037f;
		mdl_w = `CFG_DEF_WIDTH;
		mdl_h = `CFG_DEF_HEIGHT;
		mdl_vs = 0;
		mdl_hs = 0;
		mdl_fs = 1'b0;
		mdl_ax = 0;
		mdl_ay = 0;
		mdl_mask = 8'd0;
		mdl_state = 8'd0;
		resetd       <= 1'b1;
		i_host_req   <= 1'b0;
		i_host_sel   <= 1'b0;
		i_host_data  <= '0;
		i_led_status <= 8'd0;
		i_arx        <= '0;
		i_ary        <= '0;
		repeat (10) @(posedge clk_sys);
		resetd <= 1'b0;
		@(posedge clk_sys);

		start_err = errors;
		assert (o_host_ack == 1'b0) else begin
			$display("handshake: ack is high after reset");
			errors++;
		end
		send_word(16'h0000);
		end_test("handshake", start_err);

		start_err = errors;
		repeat (SETTLE_CYCLES) @(posedge clk_sys);
		check_bounds("default_window", 0, 1919, 0, 1079);
		end_test("default_window", start_err);

		// 1280x720 mode, limits 1000 by 600, free-scale on
		start_err = errors;
		frame_words = '{{8'h00, `CFG_CMD_MODE}, 16'd1280, 16'd0, 16'd0, 16'd0,
			16'd720, 16'd0, 16'd0, 16'd0};
		send_frame();
		frame_words = '{{8'h00, `CFG_CMD_VSET}, 16'd600};
		send_frame();
		frame_words = '{{8'h00, `CFG_CMD_HSET}, 16'h8000 | 16'd1000};
		send_frame();
		mdl_w = 1280;
		mdl_h = 720;
		mdl_vs = 600;
		mdl_hs = 1000;
		mdl_fs = 1'b1;
		repeat (SETTLE_CYCLES) @(posedge clk_sys);
		check_bounds("mode_limits", 140, 1139, 60, 659);
		end_test("mode_limits", start_err);

		start_err = errors;
		frame_words = '{{8'h00, `CFG_CMD_HSET}, 16'd1000};
		send_frame();
		mdl_fs = 1'b0;
		for (int n = 0; n < 8; n++) begin
			rnd = $random(seed);
			mdl_ax = 1 + int'(rnd[15:0] % 16'd255);
			mdl_ay = 1 + int'(rnd[31:16] % 16'd255);
			@(posedge clk_sys);
			i_arx <= `CFG_DIM_W'(mdl_ax);
			i_ary <= `CFG_DIM_W'(mdl_ay);
			repeat (SETTLE_CYCLES) @(posedge clk_sys);
			check_window("aspect");
		end
		end_test("aspect", start_err);

		// mask in the high byte, state in the low byte
		start_err = errors;
		rnd = $random(seed);
		mdl_mask = rnd[15:8];
		mdl_state = rnd[7:0];
		@(posedge clk_sys);
		i_led_status <= rnd[23:16];
		frame_words = '{{8'h00, `CFG_CMD_LED}, rnd[15:0]};
		send_frame();
		check_led("led_override");
		rnd = $random(seed);
		@(posedge clk_sys);
		i_led_status <= rnd[7:0];
		repeat (2) @(posedge clk_sys);
		check_led("led_override");
		end_test("led_override", start_err);

		// words without select are answered but ignored
		start_err = errors;
		send_word({8'h00, `CFG_CMD_VSET});
		send_word(16'd100);
		repeat (SETTLE_CYCLES) @(posedge clk_sys);
		check_window("framing");
		check_led("framing");
		frame_words = '{{8'h00, `CFG_CMD_VSET}, 16'd500};
		send_frame();
		mdl_vs = 500;
		rnd = $random(seed);
		mdl_mask = rnd[15:8];
		mdl_state = rnd[7:0];
		// a leftover vset frame would take this code as a height
		frame_words = '{{8'h00, `CFG_CMD_LED}, rnd[15:0]};
		send_frame();
		repeat (SETTLE_CYCLES) @(posedge clk_sys);
		check_window("framing");
		check_led("framing");
		end_test("framing", start_err);

		$display("tests: %0d, errors: %0d", tests_run, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/scaler_ctl_top.sv
//////////////////////////////////////////////////////////////////////
// scaler control top
// host link, configuration registers and window calculator
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "scaler_ctl_cfg.svh"

module scaler_ctl_top (
	input  wire                   clk_sys,
	input  wire                   resetd,
	input  wire                   i_host_req,
	input  wire                   i_host_sel,
	input  wire [`CFG_WORD_W-1:0] i_host_data,
	input  wire [7:0]             i_led_status,
	input  wire [`CFG_DIM_W-1:0]  i_arx,
	input  wire [`CFG_DIM_W-1:0]  i_ary,
	output logic                  o_host_ack,
	output logic [7:0]            o_led,
	output logic [`CFG_DIM_W-1:0] o_hmin,
	output logic [`CFG_DIM_W-1:0] o_hmax,
	output logic [`CFG_DIM_W-1:0] o_vmin,
	output logic [`CFG_DIM_W-1:0] o_vmax
);

	// link to registers
	logic                       link_strobe;
	logic                       link_sel;
	scaler_ctl_pkg::host_word_u link_word;

	// registers to calculator
	logic [`CFG_DIM_W-1:0] cfg_width;
	logic [`CFG_DIM_W-1:0] cfg_height;
	logic [`CFG_DIM_W-1:0] cfg_vset;
	logic [`CFG_DIM_W-1:0] cfg_hset;
	logic                  cfg_freescale;

	host_link host_link_i (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_host_req  (i_host_req),
		.i_host_sel  (i_host_sel),
		.i_host_data (i_host_data),
		.o_host_ack  (o_host_ack),
		.o_strobe    (link_strobe),
		.o_word      (link_word),
		.o_sel       (link_sel)
	);

	cfg_regs cfg_regs_i (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_strobe     (link_strobe),
		.i_word       (link_word),
		.i_sel        (link_sel),
		.i_led_status (i_led_status),
		.o_width      (cfg_width),
		.o_height     (cfg_height),
		.o_vset       (cfg_vset),
		.o_hset       (cfg_hset),
		.o_freescale  (cfg_freescale),
		.o_led        (o_led)
	);

	window_calc window_calc_i (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_width     (cfg_width),
		.i_height    (cfg_height),
		.i_vset      (cfg_vset),
		.i_hset      (cfg_hset),
		.i_freescale (cfg_freescale),
		.i_arx       (i_arx),
		.i_ary       (i_ary),
		.o_hmin      (o_hmin),
		.o_hmax      (o_hmax),
		.o_vmin      (o_vmin),
		.o_vmax      (o_vmax)
	);

endmodule

`default_nettype wire

// File: rtl/window_calc.sv
//////////////////////////////////////////////////////////////////////
// output window calculator
// aspect-corrected video size centred in the output mode
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "scaler_ctl_cfg.svh"

module window_calc (
	input  wire                   clk_sys,
	input  wire                   resetd,
	input  wire [`CFG_DIM_W-1:0]  i_width,
	input  wire [`CFG_DIM_W-1:0]  i_height,
	input  wire [`CFG_DIM_W-1:0]  i_vset,
	input  wire [`CFG_DIM_W-1:0]  i_hset,
	input  wire                   i_freescale,
	input  wire [`CFG_DIM_W-1:0]  i_arx,
	input  wire [`CFG_DIM_W-1:0]  i_ary,
	output logic [`CFG_DIM_W-1:0] o_hmin,
	output logic [`CFG_DIM_W-1:0] o_hmax,
	output logic [`CFG_DIM_W-1:0] o_vmin,
	output logic [`CFG_DIM_W-1:0] o_vmax
);

	localparam logic [1:0] ST_START  = 2'd0;
	localparam logic [1:0] ST_RUN_W  = 2'd1;
	localparam logic [1:0] ST_RUN_H  = 2'd2;
	localparam logic [1:0] ST_BOUNDS = 2'd3;

	logic [1:0]            state;
	logic [`CFG_DIM_W-1:0] lim_w_c, lim_h_c;
	// inputs sampled at the start of a pass
	logic [`CFG_DIM_W-1:0] mode_w, mode_h, lim_w, lim_h, ar_x, ar_y;
	logic [`CFG_DIM_W-1:0] wcalc, hcalc, videow, videoh, hoff, voff;
	logic                  md_start, md_busy;
	logic [`CFG_DIM_W-1:0] md_mul1, md_mul2, md_div, md_res;

	// a zero limit means no limit
	assign lim_w_c = (i_hset != '0 && i_hset < i_width) ? i_hset : i_width;
	assign lim_h_c = (i_vset != '0 && i_vset < i_height) ? i_vset : i_height;

	// clip to the limited size, then centre
	assign videow = (wcalc > lim_w) ? lim_w : wcalc;
	assign videoh = (hcalc > lim_h) ? lim_h : hcalc;
	assign hoff   = (mode_w - videow) >> 1;
	assign voff   = (mode_h - videoh) >> 1;

	umuldiv ar_muldiv_i (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_res)
	);

	//////////////////////////////////////////////////////////////////////
	// sequencer, runs continuously
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state    <= ST_START;
			md_start <= 1'b0;
			o_hmin   <= '0;
			o_hmax   <= '0;
			o_vmin   <= '0;
			o_vmax   <= '0;
		end else begin
			md_start <= 1'b0;
			case (state)
				ST_START: begin
					if (i_freescale || i_arx == '0 || i_ary == '0) begin
						state <= ST_BOUNDS;
					end else begin
						md_start <= 1'b1;
						state    <= ST_RUN_W;
					end
				end
				ST_RUN_W: if (!md_start && !md_busy) begin
					md_start <= 1'b1;
					state    <= ST_RUN_H;
				end
				ST_RUN_H: if (!md_start && !md_busy) state <= ST_BOUNDS;
				default: begin
					o_hmin <= hoff;
					o_hmax <= hoff + videow - 1'b1;
					o_vmin <= voff;
					o_vmax <= voff + videoh - 1'b1;
					state  <= ST_START;
				end
			endcase
		end
	end

	// sizes and divider operands
	always_ff @(posedge clk_sys) begin
		case (state)
			ST_START: begin
				{mode_w, mode_h, lim_w, lim_h} <= {i_width, i_height, lim_w_c, lim_h_c};
				{ar_x, ar_y} <= {i_arx, i_ary};
				// free-scale fills the limited area
				{wcalc, hcalc} <= {lim_w_c, lim_h_c};
				// width from height first
				{md_mul1, md_mul2, md_div} <= {lim_h_c, i_arx, i_ary};
			end
			ST_RUN_W: if (!md_start && !md_busy) begin
				wcalc <= md_res;
				{md_mul1, md_mul2, md_div} <= {lim_w, ar_y, ar_x};
			end
			ST_RUN_H: if (!md_start && !md_busy) hcalc <= md_res;
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/umuldiv.sv
//////////////////////////////////////////////////////////////////////
// unsigned multiply-divide
// result = mul1 * mul2 / div, one quotient bit per cycle
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "scaler_ctl_cfg.svh"

module umuldiv (
	input  wire                   clk_sys,
	input  wire                   resetd,
	input  wire                   i_start,
	input  wire [`CFG_DIM_W-1:0]  i_mul1,
	input  wire [`CFG_DIM_W-1:0]  i_mul2,
	input  wire [`CFG_DIM_W-1:0]  i_div,
	output logic                  o_busy,
	output logic [`CFG_DIM_W-1:0] o_result
);

	logic [2*`CFG_DIM_W-1:0] product;
	logic [`CFG_DIM_W:0]     trial;
	logic [`CFG_DIM_W:0]     diff;
	logic [`CFG_DIM_W-1:0]   rem_q;
	logic [`CFG_DIM_W-1:0]   quo_q;
	logic [`CFG_DIM_W-1:0]   div_q;
	logic [3:0]              step_cnt;
	logic                    sat_q;

	assign product = i_mul1 * i_mul2;
	// next dividend bit shifts out of the quotient register
	assign trial   = {rem_q, quo_q[`CFG_DIM_W-1]};
	assign diff    = trial - {1'b0, div_q};

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy   <= 1'b0;
			step_cnt <= 4'd0;
		end else if (i_start) begin
			o_busy   <= 1'b1;
			step_cnt <= 4'd0;
		end else if (o_busy) begin
			step_cnt <= step_cnt + 4'd1;
			if (step_cnt == 4'(`CFG_DIM_W - 1))
				o_busy <= 1'b0;
		end
	end

	// restoring division of the product, low half doubles as quotient
	always_ff @(posedge clk_sys) begin
		if (i_start) begin
			rem_q <= product[2*`CFG_DIM_W-1:`CFG_DIM_W];
			quo_q <= product[`CFG_DIM_W-1:0];
			div_q <= i_div;
			// quotient would not fit in 12 bits
			sat_q <= (product[2*`CFG_DIM_W-1:`CFG_DIM_W] >= i_div);
		end else if (o_busy) begin
			if (trial >= {1'b0, div_q}) begin
				rem_q <= diff[`CFG_DIM_W-1:0];
				quo_q <= {quo_q[`CFG_DIM_W-2:0], 1'b1};
			end else begin
				rem_q <= trial[`CFG_DIM_W-1:0];
				quo_q <= {quo_q[`CFG_DIM_W-2:0], 1'b0};
			end
		end
	end

	assign o_result = sat_q ? '1 : quo_q;

endmodule

`default_nettype wire

// File: rtl/cfg_regs.sv
//////////////////////////////////////////////////////////////////////
// configuration registers
// decodes host command frames and drives the LED override mux
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "scaler_ctl_cfg.svh"

module cfg_regs (
	input  wire                             clk_sys,
	input  wire                             resetd,
	input  wire                             i_strobe,
	input  wire scaler_ctl_pkg::host_word_u i_word,
	input  wire                             i_sel,
	input  wire [7:0]                       i_led_status,
	output logic [`CFG_DIM_W-1:0]           o_width,
	output logic [`CFG_DIM_W-1:0]           o_height,
	output logic [`CFG_DIM_W-1:0]           o_vset,
	output logic [`CFG_DIM_W-1:0]           o_hset,
	output logic                            o_freescale,
	output logic [7:0]                      o_led
);

	// frame state
	logic       has_cmd;
	logic [7:0] cmd;
	logic [3:0] cnt;

	// led override, mask in the high byte of the word
	logic [7:0] led_mask;
	logic [7:0] led_state;

	//////////////////////////////////////////////////////////////////////
	// command decode
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd     <= 1'b0;
			cmd         <= 8'd0;
			cnt         <= 4'd0;
			o_width     <= `CFG_DIM_W'(`CFG_DEF_WIDTH);
			o_height    <= `CFG_DIM_W'(`CFG_DEF_HEIGHT);
			o_vset      <= '0;
			o_hset      <= '0;
			o_freescale <= 1'b0;
			led_mask    <= 8'd0;
			led_state   <= 8'd0;
		end else if (!i_sel) begin
			// frame ended, next word is a command again
			has_cmd <= 1'b0;
			cmd     <= 8'd0;
			cnt     <= 4'd0;
		end else if (i_strobe) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= i_word.cmd.code;
				cnt     <= 4'd0;
			end else begin
				// parameter index, held at the top
				if (cnt != 4'hf)
					cnt <= cnt + 4'd1;

				case (cmd)
					`CFG_CMD_MODE: begin
						// only width and height, timing words skipped
						if (cnt == 4'd0)
							o_width <= i_word.prm.value;
						if (cnt == 4'd4)
							o_height <= i_word.prm.value;
					end
					`CFG_CMD_LED: begin
						{led_mask, led_state} <= i_word;
					end
					`CFG_CMD_VSET: begin
						o_vset <= i_word.prm.value;
					end
					`CFG_CMD_HSET: begin
						o_freescale <= i_word.prm.flag;
						o_hset      <= i_word.prm.value;
					end
					default: begin
						// unknown commands are swallowed
					end
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// led mux
	//////////////////////////////////////////////////////////////////////

	// host state where overridden, core status elsewhere
	assign o_led = (led_mask & led_state) | (~led_mask & i_led_status);

endmodule

`default_nettype wire

// File: rtl/host_link.sv
//////////////////////////////////////////////////////////////////////
// host link
// synchronises the req/ack word transfer and strobes each word once
//////////////////////////////////////////////////////////////////////

`default_nettype none

module host_link (
	input  wire                        clk_sys,
	input  wire                        resetd,
	input  wire                        i_host_req,
	input  wire                        i_host_sel,
	input  wire scaler_ctl_pkg::host_word_u i_host_data,
	output logic                       o_host_ack,
	output logic                       o_strobe,
	output scaler_ctl_pkg::host_word_u o_word,
	output logic                       o_sel
);

	logic req_meta;
	logic req_sync;
	logic req_prev;
	logic sel_meta;
	logic req_rise;
	scaler_ctl_pkg::host_word_u data_meta;
	scaler_ctl_pkg::host_word_u data_sync;

	assign req_rise = req_sync & ~req_prev;

	// two stage synchronisers, edge detect and four-phase ack
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			req_meta   <= 1'b0;
			req_sync   <= 1'b0;
			req_prev   <= 1'b0;
			sel_meta   <= 1'b0;
			o_sel      <= 1'b0;
			o_strobe   <= 1'b0;
			o_host_ack <= 1'b0;
		end else begin
			req_meta <= i_host_req;
			req_sync <= req_meta;
			req_prev <= req_sync;
			sel_meta <= i_host_sel;
			o_sel    <= sel_meta;
			o_strobe <= req_rise;
			// raise after the strobe, drop once req has gone
			if (o_strobe)
				o_host_ack <= 1'b1;
			else if (!req_sync)
				o_host_ack <= 1'b0;
		end
	end

	// data is held by the host while req is high
	always_ff @(posedge clk_sys) begin
		data_meta <= i_host_data;
		data_sync <= data_meta;
		if (req_rise)
			o_word <= data_sync;
	end

endmodule

`default_nettype wire

// File: rtl/scaler_ctl_pkg.sv
//////////////////////////////////////////////////////////////////////
// scaler control types
// host word, seen as a command code or as a flagged parameter
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "scaler_ctl_cfg.svh"

package scaler_ctl_pkg;

	// first word of a frame
	typedef struct packed {
		logic [`CFG_WORD_W-9:0] rsvd;
		logic [7:0]             code;
	} cmd_view_t;

	// later words, flag is free-scale for the hset command
	typedef struct packed {
		logic                            flag;
		logic [`CFG_WORD_W-`CFG_DIM_W-2:0] rsvd;
		logic [`CFG_DIM_W-1:0]           value;
	} prm_view_t;

	typedef union packed {
		cmd_view_t cmd;
		prm_view_t prm;
	} host_word_u;

endpackage

`default_nettype wire

// File: rtl/scaler_ctl_cfg.svh
//////////////////////////////////////////////////////////////////////
// scaler control constants
// word widths, host command codes and reset mode size
//////////////////////////////////////////////////////////////////////

`ifndef SCALER_CTL_CFG_SVH
`define SCALER_CTL_CFG_SVH

// host word and dimension widths
`define CFG_WORD_W 16
`define CFG_DIM_W  12

// host command codes, low byte of the first word in a frame
`define CFG_CMD_MODE 8'h20
`define CFG_CMD_LED  8'h25
`define CFG_CMD_VSET 8'h27
`define CFG_CMD_HSET 8'h37

// output mode after reset, 1080p
`define CFG_DEF_WIDTH  1920
`define CFG_DEF_HEIGHT 1080

`endif
